//--- include/lease_consts.svh
/* sizes, widths and generator seeds for the lease replacement engine,
   included by every module that needs a width */
`ifndef LEASE_CONSTS_SVH
`define LEASE_CONSTS_SVH

// lease lookup table
// --------------------
`define LEASE_LLT_ENTRIES   8                       // entries in the table
`define LEASE_LLT_ENTRY_BW  3                       // entry index width
`define LEASE_LLT_ADDR_BW   (`LEASE_LLT_ENTRY_BW + 2) // field select + entry
`define LEASE_DATA_BW       32                      // config write word

`define LEASE_VALUE_BW      8   // lease counter width
`define LEASE_REF_ADDR_BW   16  // reference address tag
`define LEASE_PROB_BW       9   // 256 means always lease0

// cache
// --------------------
`define LEASE_CACHE_BLOCKS  8   // fully associative, power of two
`define LEASE_CACHE_ADDR_BW 3   // line index width

`define LEASE_PROB_SEED     8'hA5 // nonzero, lease select generator
`define LEASE_EVICT_SEED    8'h5B // nonzero, random eviction generator

`endif

//--- logic/lease_pkg.sv
/* shared enums of the lease engine, referenced by scoped name
   from the table and the replacement controller */
package lease_pkg;

	// controller states
	// --------------------
	// NORMAL takes hit and miss strobes,
	// GEN_REPLACEMENT is the one extra cycle of an allocating miss
	typedef enum logic {
		NORMAL          = 1'b0,  // idle, counted and follow-up hits
		GEN_REPLACEMENT = 1'b1   // pick a victim line
	} lease_state_e;

	// table field select
	// --------------------
	// top two bits of llt_addr_i, low bits pick the entry
	typedef enum logic [1:0] {
		TAG    = 2'd0,  // reference address, also sets valid
		LEASE0 = 2'd1,  // first candidate lease
		LEASE1 = 2'd2,  // second candidate lease
		PROB   = 2'd3   // probability of lease0, 9 bits
	} lease_field_e;

endpackage

//--- logic/lease_lookup_if.sv
/* combinational lookup result of the lease table, read by the
   probability selector and the replacement controller */
`timescale 1ns/10ps
`include "lease_consts.svh"

interface lease_lookup_if;

	logic                       hit;          // search address matched a valid tag
	logic [`LEASE_VALUE_BW-1:0] lease0;       // first candidate lease
	logic [`LEASE_VALUE_BW-1:0] lease1;       // second candidate lease
	logic [`LEASE_PROB_BW-1:0]  lease0_prob;  // chance of lease0, out of 256

	// table drives everything
	modport table_mp (output hit, output lease0, output lease1, output lease0_prob);

	// selector only needs the candidates
	modport select_mp (input lease0, input lease1, input lease0_prob);

	// controller only needs to know if the table matched
	modport ctrl_mp (input hit);

endinterface

//--- logic/lease_lookup_table.sv
/* lease lookup table, written field by field from the config port and
   searched in parallel against the reference address of each access */
`timescale 1ns/10ps
`include "lease_consts.svh"

module lease_lookup_table (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  logic                          llt_wren_i,    // write llt_data_i into addressed field
	input  logic [`LEASE_LLT_ADDR_BW-1:0] llt_addr_i,    // {field, entry}
	input  logic [`LEASE_DATA_BW-1:0]     llt_data_i,
	input  logic [`LEASE_REF_ADDR_BW-1:0] search_addr_i, // reference address to look up
	lease_lookup_if.table_mp              lkp
);

	logic                          valid_q  [`LEASE_LLT_ENTRIES];
	logic [`LEASE_REF_ADDR_BW-1:0] tag_q    [`LEASE_LLT_ENTRIES];
	logic [`LEASE_VALUE_BW-1:0]    lease0_q [`LEASE_LLT_ENTRIES];
	logic [`LEASE_VALUE_BW-1:0]    lease1_q [`LEASE_LLT_ENTRIES];
	logic [`LEASE_PROB_BW-1:0]     prob_q   [`LEASE_LLT_ENTRIES];

	lease_pkg::lease_field_e         wr_field;
	logic [`LEASE_LLT_ENTRY_BW-1:0]  wr_entry;

	assign wr_field = lease_pkg::lease_field_e'(llt_addr_i[`LEASE_LLT_ADDR_BW-1 -: 2]);
	assign wr_entry = llt_addr_i[`LEASE_LLT_ENTRY_BW-1:0];

	// write port
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < `LEASE_LLT_ENTRIES; i++) valid_q[i] <= 1'b0; // empty table
		end else if (llt_wren_i && (wr_field == lease_pkg::TAG)) begin
			valid_q[wr_entry] <= 1'b1; // tag write makes the entry live
		end
	end

	// field payload, valid bit guards it
	always_ff @(posedge clock_i) begin
		if (llt_wren_i) begin
			case (wr_field)
				lease_pkg::TAG:    tag_q[wr_entry]    <= llt_data_i[`LEASE_REF_ADDR_BW-1:0];
				lease_pkg::LEASE0: lease0_q[wr_entry] <= llt_data_i[`LEASE_VALUE_BW-1:0];
				lease_pkg::LEASE1: lease1_q[wr_entry] <= llt_data_i[`LEASE_VALUE_BW-1:0];
				lease_pkg::PROB:   prob_q[wr_entry]   <= llt_data_i[`LEASE_PROB_BW-1:0];
				default: ;
			endcase
		end
	end

	// search port
	// --------------------
	// walk from the top entry down so the lowest match is the one left standing
	always_comb begin
		lkp.hit         = 1'b0;
		lkp.lease0      = '0;
		lkp.lease1      = '0;
		lkp.lease0_prob = '0;
		for (int i = `LEASE_LLT_ENTRIES - 1; i >= 0; i--) begin
			if (valid_q[i] && (tag_q[i] == search_addr_i)) begin
				lkp.hit         = 1'b1;
				lkp.lease0      = lease0_q[i];
				lkp.lease1      = lease1_q[i];
				lkp.lease0_prob = prob_q[i];
			end
		end
	end

endmodule

//--- logic/lease_probability_select.sv
/* picks lease0 or lease1 of the current table match, using an 8-bit LFSR
   compared against the lease0 probability; steps on advance_i */
`timescale 1ns/10ps
`include "lease_consts.svh"

module lease_probability_select (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        advance_i, // one strobe per accepted access
	lease_lookup_if.select_mp           lkp,
	output logic [`LEASE_VALUE_BW-1:0]  lease_o    // chosen lease
);

	logic [7:0] lfsr_q;     // never zero, runs 1..255
	logic       lfsr_fb;

	// x^8 + x^6 + x^5 + x^4 + 1, maximal length
	assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			lfsr_q <= `LEASE_PROB_SEED;
		end else if (advance_i) begin
			lfsr_q <= {lfsr_q[6:0], lfsr_fb};
		end
	end

	// compare
	// --------------------
	// generator is at most 255 so prob 256 always gives lease0,
	// and it is never below 0 so prob 0 always gives lease1
	always_comb begin
		if ({1'b0, lfsr_q} < lkp.lease0_prob) begin
			lease_o = lkp.lease0;
		end else begin
			lease_o = lkp.lease1; // lower probability lease
		end
	end

endmodule

//--- logic/lease_replacement_controller.sv
/* per-line lease counters and replacement address generation; takes hit and
   miss strobes from the cache controller and answers with done_o and addr_o */
`timescale 1ns/10ps
`include "lease_consts.svh"

module lease_replacement_controller (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           con_wren_i,  // config register write
	input  logic [`LEASE_LLT_ADDR_BW-1:0]  llt_addr_i,  // config address, 0 is the default lease
	input  logic [`LEASE_DATA_BW-1:0]      llt_data_i,
	input  logic [`LEASE_CACHE_ADDR_BW-1:0] cache_addr_i, // line being referenced
	input  logic                           hit_i,       // strobe
	input  logic                           miss_i,      // strobe
	input  logic [`LEASE_VALUE_BW-1:0]     lease_i,     // lease from the selector
	lease_lookup_if.ctrl_mp                lkp,
	output logic                           advance_o,   // steps the selector LFSR
	output logic                           done_o,
	output logic [`LEASE_CACHE_ADDR_BW-1:0] addr_o,     // replacement line
	output logic                           swap_o,      // missed block is allocated
	output logic                           expired_o,
	output logic                           expired_multi_o,
	output logic                           default_o,   // default lease was used
	output logic                           rand_evict_o
);

	logic [`LEASE_VALUE_BW-1:0]      cnt_q   [`LEASE_CACHE_BLOCKS]; // one per line
	logic [`LEASE_VALUE_BW-1:0]      cnt_dec [`LEASE_CACHE_BLOCKS]; // saturating at zero
	logic [`LEASE_VALUE_BW-1:0]      default_lease_q;
	logic [`LEASE_VALUE_BW-1:0]      saved_lease_q; // lease waiting for the follow-up hit
	logic [`LEASE_VALUE_BW-1:0]      miss_lease;
	lease_pkg::lease_state_e         state_q;
	logic                            followup_q;    // next hit installs saved_lease_q
	logic [`LEASE_CACHE_ADDR_BW-1:0] cold_ptr_q;
	logic                            full_q;        // every line allocated once
	logic [`LEASE_CACHE_BLOCKS-1:0]  zero_flags;
	logic [`LEASE_CACHE_ADDR_BW-1:0] low_idx, high_idx;
	logic [7:0]                      evict_lfsr_q;
	logic                            evict_fb;
	logic                            accept;

	// strobes are ignored while a victim is being picked
	assign accept     = (state_q == lease_pkg::NORMAL) && (hit_i || miss_i);
	assign advance_o  = accept;
	assign miss_lease = lkp.hit ? lease_i : default_lease_q;
	assign evict_fb   = evict_lfsr_q[7] ^ evict_lfsr_q[5] ^ evict_lfsr_q[4] ^ evict_lfsr_q[3];

	// expired lines
	// --------------------
	always_comb begin
		low_idx  = '0;
		high_idx = '0;
		for (int i = 0; i < `LEASE_CACHE_BLOCKS; i++) begin
			zero_flags[i] = (cnt_q[i] == '0);
			cnt_dec[i]    = zero_flags[i] ? cnt_q[i] : cnt_q[i] - 1'b1;
		end
		for (int i = `LEASE_CACHE_BLOCKS - 1; i >= 0; i--) // lowest zero wins
			if (zero_flags[i]) low_idx = `LEASE_CACHE_ADDR_BW'(i);
		for (int i = 0; i < `LEASE_CACHE_BLOCKS; i++)      // highest zero wins
			if (zero_flags[i]) high_idx = `LEASE_CACHE_ADDR_BW'(i);
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && (llt_addr_i == '0)) begin
			default_lease_q <= llt_data_i[`LEASE_VALUE_BW-1:0];
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept && miss_i) saved_lease_q <= miss_lease; // only read after an allocating miss
	end

	// control FSM
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= lease_pkg::NORMAL;
			followup_q   <= 1'b0;
			cold_ptr_q   <= '0;
			full_q       <= 1'b0;
			evict_lfsr_q <= `LEASE_EVICT_SEED;
			done_o       <= 1'b0;
			addr_o       <= '0;
			swap_o       <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			rand_evict_o    <= 1'b0;
			for (int i = 0; i < `LEASE_CACHE_BLOCKS; i++) cnt_q[i] <= '0;
		end else begin
			expired_o       <= 1'b0; // status flags are single-cycle pulses
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			rand_evict_o    <= 1'b0;
			case (state_q)
				lease_pkg::NORMAL: begin
					if (hit_i && followup_q) begin
						followup_q          <= 1'b0; // counters already stepped on the miss
						cnt_q[cache_addr_i] <= saved_lease_q;
					end else if (hit_i) begin
						for (int i = 0; i < `LEASE_CACHE_BLOCKS; i++) cnt_q[i] <= cnt_dec[i];
						cnt_q[cache_addr_i] <= miss_lease; // renew, overrides the decrement
						default_o           <= !lkp.hit;
					end else if (miss_i) begin
						for (int i = 0; i < `LEASE_CACHE_BLOCKS; i++) cnt_q[i] <= cnt_dec[i];
						default_o <= !lkp.hit;
						if (miss_lease != '0) begin
							done_o     <= 1'b0; // one more cycle for the victim
							followup_q <= 1'b1;
							state_q    <= lease_pkg::GEN_REPLACEMENT;
						end else begin
							done_o <= 1'b1;     // just service it, no allocation
							swap_o <= 1'b0;
						end
					end
				end
				lease_pkg::GEN_REPLACEMENT: begin
					done_o  <= 1'b1;
					swap_o  <= 1'b1;
					state_q <= lease_pkg::NORMAL;
					if (!full_q) begin
						addr_o     <= cold_ptr_q; // cold start fill, in order
						cold_ptr_q <= cold_ptr_q + 1'b1;
						if (cold_ptr_q == {`LEASE_CACHE_ADDR_BW{1'b1}}) full_q <= 1'b1;
					end else if (|zero_flags) begin
						addr_o          <= low_idx;
						expired_o       <= 1'b1;
						expired_multi_o <= (low_idx != high_idx);
					end else begin
						// nothing expired, fall back to a pseudo-random line
						addr_o       <= evict_lfsr_q[`LEASE_CACHE_ADDR_BW-1:0];
						rand_evict_o <= 1'b1;
						evict_lfsr_q <= {evict_lfsr_q[6:0], evict_fb};
					end
				end
				default: state_q <= lease_pkg::NORMAL;
			endcase
		end
	end

endmodule

//--- logic/lease_cache_policy_top.sv
/* lease replacement policy engine; the cache controller drives the config
   and strobe ports and reads back the replacement address and status */
`timescale 1ns/10ps
`include "lease_consts.svh"

module lease_cache_policy_top (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  logic                            con_wren_i,    // default lease write
	input  logic                            llt_wren_i,    // table field write
	input  logic [`LEASE_LLT_ADDR_BW-1:0]   llt_addr_i,
	input  logic [`LEASE_DATA_BW-1:0]       llt_data_i,
	input  logic [`LEASE_REF_ADDR_BW-1:0]   search_addr_i, // reference address of the access
	input  logic [`LEASE_CACHE_ADDR_BW-1:0] cache_addr_i,
	input  logic                            hit_i,
	input  logic                            miss_i,
	output logic                            done_o,
	output logic [`LEASE_CACHE_ADDR_BW-1:0] addr_o,
	output logic                            swap_o,
	output logic                            expired_o,
	output logic                            expired_multi_o,
	output logic                            default_o,
	output logic                            rand_evict_o
);

	lease_lookup_if lkp_if ();

	logic [`LEASE_VALUE_BW-1:0] sel_lease; // selector to controller
	logic                       advance;   // controller to selector

	lease_lookup_table i_table (
		.clock_i, .resetn_i, .llt_wren_i, .llt_addr_i, .llt_data_i, .search_addr_i,
		.lkp (lkp_if.table_mp)
	);

	lease_probability_select i_select (
		.clock_i, .resetn_i,
		.advance_i (advance),
		.lkp       (lkp_if.select_mp),
		.lease_o   (sel_lease)
	);

	lease_replacement_controller i_ctrl (
		.clock_i, .resetn_i, .con_wren_i, .llt_addr_i, .llt_data_i, .cache_addr_i,
		.hit_i, .miss_i,
		.lease_i   (sel_lease),
		.lkp       (lkp_if.ctrl_mp),
		.advance_o (advance),
		.done_o, .addr_o, .swap_o, .expired_o, .expired_multi_o, .default_o, .rand_evict_o
	);

endmodule

//--- verif/lease_policy_chk.sv
/* protocol assertions on the lease policy top, attached with bind
   from the testbench */
`timescale 1ns/10ps

module lease_policy_chk (
	input logic clock_i,
	input logic resetn_i,
	input logic hit_i,
	input logic miss_i,
	input logic done_i,          // done_o of the top
	input logic expired_i,
	input logic expired_multi_i,
	input logic rand_evict_i
);

	a_one_strobe: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i)) else $error("hit_i and miss_i high in the same cycle");

	// victim comes either from an expired line or from the generator
	a_one_source: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(expired_i && rand_evict_i)) else $error("expired_o and rand_evict_o both high");

	a_multi: assert property (@(posedge clock_i) disable iff (!resetn_i)
		expired_multi_i |-> expired_i) else $error("expired_multi_o without expired_o");

	// allocating miss drops done for exactly one edge
	a_alloc_done: assert property (@(posedge clock_i) disable iff (!resetn_i)
		($past(miss_i) && !done_i) |=> done_i) else $error("done_o late after a miss");

endmodule

//--- verif/lease_policy_tb.sv
/* directed testbench for the lease replacement engine; plays the cache
   controller and checks every answer against a counter model */
`timescale 1ns/10ps
`include "lease_consts.svh"

module lease_policy_tb;

	localparam int CLK_PERIOD      = 4;
	localparam int WATCHDOG_CYCLES = 2000; // all tests need well under this
	localparam int BLOCKS          = `LEASE_CACHE_BLOCKS;

	logic                            clock_i, resetn_i;
	logic                            con_wren_i, llt_wren_i, hit_i, miss_i;
	logic [`LEASE_LLT_ADDR_BW-1:0]   llt_addr_i;
	logic [`LEASE_DATA_BW-1:0]       llt_data_i;
	logic [`LEASE_REF_ADDR_BW-1:0]   search_addr_i;
	logic [`LEASE_CACHE_ADDR_BW-1:0] cache_addr_i, addr_o;
	logic                            done_o, swap_o, expired_o, expired_multi_o;
	logic                            default_o, rand_evict_o;

	// reference model of counters, default lease, cold pointer and table
	logic [`LEASE_VALUE_BW-1:0]    cnt_m    [BLOCKS];
	logic [`LEASE_VALUE_BW-1:0]    dflt_m;
	int                            cold_m;
	logic                          tab_valid [`LEASE_LLT_ENTRIES];
	logic [`LEASE_REF_ADDR_BW-1:0] tab_tag   [`LEASE_LLT_ENTRIES];
	logic [`LEASE_VALUE_BW-1:0]    tab_l0    [`LEASE_LLT_ENTRIES];
	logic [`LEASE_VALUE_BW-1:0]    tab_l1    [`LEASE_LLT_ENTRIES];
	logic [`LEASE_PROB_BW-1:0]     tab_prob  [`LEASE_LLT_ENTRIES];

	int     errors;
	integer seed;
	logic   got_default, got_first_done; // sampled one edge after a strobe

	lease_cache_policy_top i_dut (.*);

	bind lease_cache_policy_top lease_policy_chk i_chk (
		.clock_i, .resetn_i, .hit_i, .miss_i,
		.done_i (done_o), .expired_i (expired_o),
		.expired_multi_i (expired_multi_o), .rand_evict_i (rand_evict_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
	end

	initial begin
		#(CLK_PERIOD * (WATCHDOG_CYCLES + 50));
		$display("watchdog expired, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	// compare tasks
	// --------------------
	task automatic check_addr(input string name, input logic [`LEASE_CACHE_ADDR_BW-1:0] exp_v,
			input logic [`LEASE_CACHE_ADDR_BW-1:0] act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
		end
	endtask

	// model helpers
	// --------------------
	// only probabilities 256 and 0 are used, so the selector is predictable
	function automatic logic [`LEASE_VALUE_BW-1:0] model_lease(
			input logic [`LEASE_REF_ADDR_BW-1:0] ref_addr, output logic tabled);
		logic [`LEASE_VALUE_BW-1:0] lease;
		lease  = dflt_m;
		tabled = 1'b0;
		for (int i = `LEASE_LLT_ENTRIES - 1; i >= 0; i--) begin // lowest match wins
			if (tab_valid[i] && (tab_tag[i] == ref_addr)) begin
				tabled = 1'b1;
				lease  = (tab_prob[i] == 9'd256) ? tab_l0[i] : tab_l1[i];
			end
		end
		return lease;
	endfunction

	task automatic decrement_model();
		for (int i = 0; i < BLOCKS; i++)
			if (cnt_m[i] != '0) cnt_m[i] = cnt_m[i] - 1'b1; // stops at zero
	endtask

	function automatic logic [`LEASE_REF_ADDR_BW-1:0] rand_ref();
		logic [31:0] r;
		r = $random(seed);
		return {4'h1, r[11:0]}; // never collides with the table tags
	endfunction

	// drivers
	// --------------------
	task automatic write_field(input lease_pkg::lease_field_e field,
			input logic [`LEASE_LLT_ENTRY_BW-1:0] entry, input logic [`LEASE_DATA_BW-1:0] data);
		llt_addr_i = {field, entry};
		llt_data_i = data;
		llt_wren_i = 1'b1;
		@(posedge clock_i);
		#1;
		llt_wren_i = 1'b0;
		case (field)
			lease_pkg::TAG: begin
				tab_tag[entry]   = data[`LEASE_REF_ADDR_BW-1:0];
				tab_valid[entry] = 1'b1;
			end
			lease_pkg::LEASE0: tab_l0[entry] = data[`LEASE_VALUE_BW-1:0];
			lease_pkg::LEASE1: tab_l1[entry] = data[`LEASE_VALUE_BW-1:0];
			default:           tab_prob[entry] = data[`LEASE_PROB_BW-1:0];
		endcase
	endtask

	task automatic set_default(input logic [`LEASE_VALUE_BW-1:0] value);
		llt_addr_i = '0;          // address 0 is the default lease register
		llt_data_i = 32'(value);
		con_wren_i = 1'b1;
		@(posedge clock_i);
		#1;
		con_wren_i = 1'b0;
		dflt_m     = value;
	endtask

	task automatic do_hit(input logic [`LEASE_CACHE_ADDR_BW-1:0] line,
			input logic [`LEASE_REF_ADDR_BW-1:0] ref_addr);
		cache_addr_i  = line;
		search_addr_i = ref_addr;
		hit_i         = 1'b1;
		@(posedge clock_i);
		#1;
		hit_i       = 1'b0;
		got_default = default_o;
	endtask

	task automatic do_miss(input logic [`LEASE_REF_ADDR_BW-1:0] ref_addr);
		int waited;
		search_addr_i = ref_addr;
		miss_i        = 1'b1;
		@(posedge clock_i);
		#1;
		miss_i         = 1'b0;
		got_default    = default_o;
		got_first_done = done_o;
		waited         = 0;
		while (!done_o && (waited < 8)) begin // allocating miss takes one more edge
			@(posedge clock_i);
			#1;
			waited++;
		end
		if (!done_o) begin
			errors++;
			$display("done_o did not come back after a miss at %0t", $time);
		end
	endtask

	// accesses checked against the model
	// --------------------
	task automatic hit_access(input logic [`LEASE_CACHE_ADDR_BW-1:0] line,
			input logic [`LEASE_REF_ADDR_BW-1:0] ref_addr);
		logic [`LEASE_VALUE_BW-1:0] lease;
		logic                       tabled;
		lease = model_lease(ref_addr, tabled);
		decrement_model();
		cnt_m[line] = lease; // renewal overrides the decrement
		do_hit(line, ref_addr);
		check_flag("default_o", !tabled, got_default);
	endtask

	task automatic miss_access(input logic [`LEASE_REF_ADDR_BW-1:0] ref_addr);
		logic [`LEASE_VALUE_BW-1:0]      lease;
		logic [`LEASE_CACHE_ADDR_BW-1:0] victim;
		logic                            tabled, alloc, exp_expired, exp_multi, exp_rand;
		int                              low, high;
		lease = model_lease(ref_addr, tabled);
		alloc = (lease != '0);
		decrement_model();
		low  = -1;
		high = -1;
		for (int i = 0; i < BLOCKS; i++) begin
			if (cnt_m[i] == '0) begin
				if (low < 0) low = i;
				high = i;
			end
		end
		exp_expired = alloc && (cold_m >= BLOCKS) && (low >= 0);
		exp_multi   = exp_expired && (low != high);
		exp_rand    = alloc && (cold_m >= BLOCKS) && (low < 0);
		do_miss(ref_addr);
		check_flag("default_o", !tabled, got_default);
		check_flag("done_o", !alloc, got_first_done); // low for one edge only when allocating
		check_flag("swap_o", alloc, swap_o);
		check_flag("expired_o", exp_expired, expired_o);
		check_flag("expired_multi_o", exp_multi, expired_multi_o);
		check_flag("rand_evict_o", exp_rand, rand_evict_o);
		if (!alloc) return;
		if (cold_m < BLOCKS) begin
			victim = `LEASE_CACHE_ADDR_BW'(cold_m);
			check_addr("addr_o", victim, addr_o);
			cold_m++;
		end else if (exp_expired) begin
			victim = `LEASE_CACHE_ADDR_BW'(low);
			check_addr("addr_o", victim, addr_o);
		end else begin
			victim = addr_o; // random line, the model follows the DUT's pick
			if ($isunknown(addr_o)) begin
				errors++;
				$display("random victim is not a known line at %0t", $time);
			end
		end
		do_hit(victim, ref_addr); // follow-up installs the saved lease
		check_flag("default_o", 1'b0, got_default);
		cnt_m[victim] = lease;
	endtask

	// directed tests
	// --------------------
	task automatic test_cold_start(input int fills);
		for (int i = 0; i < fills; i++) miss_access(rand_ref());
	endtask

	task automatic test_zero_lease();
		set_default(8'd0);
		miss_access(rand_ref()); // serviced without allocation
		set_default(8'd3);
	endtask

	task automatic test_table_select();
		write_field(lease_pkg::TAG, 3'd0, 32'hA001);
		write_field(lease_pkg::LEASE0, 3'd0, 32'd1);
		write_field(lease_pkg::LEASE1, 3'd0, 32'd9);
		write_field(lease_pkg::PROB, 3'd0, 32'd256); // always lease0
		write_field(lease_pkg::TAG, 3'd1, 32'hB002);
		write_field(lease_pkg::LEASE0, 3'd1, 32'd9);
		write_field(lease_pkg::LEASE1, 3'd1, 32'd1);
		write_field(lease_pkg::PROB, 3'd1, 32'd0);   // always lease1
		set_default(8'd20);
		for (int i = 0; i < BLOCKS; i++) hit_access(`LEASE_CACHE_ADDR_BW'(i), rand_ref());
		hit_access(3'd2, 16'hA001);
		hit_access(3'd5, 16'hB002);
		miss_access(rand_ref()); // lines 2 and 5 both expired
		miss_access(rand_ref()); // only line 5 left
	endtask

	task automatic test_random_evict();
		set_default(8'd200);
		for (int i = 0; i < BLOCKS; i++) hit_access(`LEASE_CACHE_ADDR_BW'(i), rand_ref());
		miss_access(rand_ref());
		miss_access(rand_ref());
	endtask

	task automatic test_renewal();
		set_default(8'd12);
		for (int i = 0; i < BLOCKS; i++) hit_access(`LEASE_CACHE_ADDR_BW'(i), rand_ref());
		for (int round = 0; round < 4; round++) begin
			repeat (3) hit_access(3'd7, rand_ref()); // others age, line 7 stays fresh
			miss_access(rand_ref());
		end
	endtask

	initial begin
		seed          = 32'ha5ae;
		errors        = 0;
		resetn_i      = 1'b0;
		con_wren_i    = 1'b0;
		llt_wren_i    = 1'b0;
		hit_i         = 1'b0;
		miss_i        = 1'b0;
		llt_addr_i    = '0;
		llt_data_i    = '0;
		search_addr_i = '0;
		cache_addr_i  = '0;
		dflt_m        = '0;
		cold_m        = 0;
		for (int i = 0; i < BLOCKS; i++) cnt_m[i] = '0;
		for (int i = 0; i < `LEASE_LLT_ENTRIES; i++) tab_valid[i] = 1'b0;
		repeat (5) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;
		check_flag("done_o", 1'b0, done_o);
		check_flag("swap_o", 1'b0, swap_o);
		check_flag("expired_o", 1'b0, expired_o);
		check_flag("expired_multi_o", 1'b0, expired_multi_o);
		check_flag("default_o", 1'b0, default_o);
		check_flag("rand_evict_o", 1'b0, rand_evict_o);
		check_addr("addr_o", '0, addr_o);
		set_default(8'd3);
		test_cold_start(4);
		test_zero_lease();
		test_cold_start(4); // pointer resumes at line 4
		test_table_select();
		test_random_evict();
		test_renewal();
		$display("tests finished with %0d errors", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
logic/lease_pkg.sv
logic/lease_lookup_if.sv
logic/lease_lookup_table.sv
logic/lease_probability_select.sv
logic/lease_replacement_controller.sv
logic/lease_cache_policy_top.sv
verif/lease_policy_chk.sv
verif/lease_policy_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lease policy testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module lease_policy_tb -o lease_policy_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/lease_policy_sim)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
